//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_id_stage
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, pass if the log holds the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/id_stage_props.sv
// ~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the ID/EX barrier, bound into id_barrier.
// ~~~~~~~~~~~~~~~~~~~~

module id_stage_props import id_decode_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   stall_id,
    input id_ex_t ex
);

    // Payload without the valid bit.
    logic [134:0] held;
    assign held = {ex.pc, ex.insn, ex.use_rd, ex.rs1_val, ex.rs2_val,
                   ex.branch, ex.branch_predict, ex.trap, ex.cause};

    reset_clears: assert property (@(posedge clk) rst |=> !ex.valid && !ex.trap)
        else $error("ex.valid or ex.trap set in the cycle after reset");

    stall_holds: assert property (@(posedge clk) disable iff (rst)
        stall_id |=> held == $past(held))
        else $error("ex payload changed while stall_id was high");

    valid_or_trap: assert property (@(posedge clk) disable iff (rst) !(ex.valid && ex.trap))
        else $error("ex.valid and ex.trap both high");

endmodule

bind id_barrier id_stage_props i_id_stage_props (
    .clk      (clk),
    .rst      (rst),
    .stall_id (stall_id),
    .ex       (ex)
);

//--- bench/id_model.svh
// ~~~~~~~~~~~~~~~~~~~~
// Reference model of decode, register file and ID/EX barrier.
// Included inside the testbench module, after its signal declarations.
// ~~~~~~~~~~~~~~~~~~~~

`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

xlen_t  model_regs [32];
id_ex_t exp_ex;

// Legality per major opcode, RV32I with M and Zicsr.
function automatic logic is_legal(insn_t w);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ok;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:2])
        OP_LOAD:     ok = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        OP_MISC_MEM: ok = f3 inside {3'd0, 3'd1};
        OP_OP_IMM:   ok = !(f3 == 3'd1 && f7 != 7'h00)
                         && !(f3 == 3'd5 && !(f7 inside {7'h00, 7'h20}));
        OP_AUIPC, OP_LUI, OP_JAL: ok = 1'b1;
        OP_STORE:    ok = f3 inside {3'd0, 3'd1, 3'd2};
        OP_OP:       ok = f7 == 7'h00 || (f7 == 7'h20 && (f3 inside {3'd0, 3'd5}))
                         || (f7 == 7'h01 && has_m);
        OP_BRANCH:   ok = !(f3 inside {3'd2, 3'd3});
        OP_JALR:     ok = f3 == 3'd0;
        // ECALL, EBREAK, WFI and MRET, or a CSR access.
        OP_SYSTEM:   ok = (f3 == 3'd0) ? (w[31:20] inside {12'h000, 12'h001, 12'h105, 12'h302})
                                      : (f3 != 3'd4 && has_zicsr);
        default:     ok = 1'b0;
    endcase
    return ok && w[1:0] == 2'b11;
endfunction

function automatic logic writes_rd(insn_t w);
    case (w[6:2])
        OP_LOAD, OP_OP_IMM, OP_AUIPC, OP_LUI, OP_OP, OP_JAL, OP_JALR: return 1'b1;
        OP_SYSTEM: return w[14:12] != 3'd0;
        default:   return 1'b0;
    endcase
endfunction

// Write-first read of the model registers.
function automatic xlen_t read_model_reg(reg_idx_t idx);
    if (idx == 5'd0) begin
        return '0;
    end
    if (wb.we && wb.rd == idx) begin
        return wb.wdata;
    end
    return model_regs[idx];
endfunction

// Control-flow info for the instruction now on the fetch input.
function automatic branch_t expect_branch();
    branch_t b;
    insn_t   w;
    xlen_t   imm;
    xlen_t   base;
    w           = fetch.insn;
    imm         = '0;
    base        = {fetch.pc, 1'b0};
    b.is_jump   = w[6:2] == OP_JAL || w[6:2] == OP_JALR;
    b.is_branch = w[6:2] == OP_BRANCH;
    b.is_xret   = w[6:2] == OP_SYSTEM && w[14:12] == 3'd0 && w[31:20] == 12'h302;
    b.predict   = w[31];
    case (w[6:2])
        OP_JAL:    imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        OP_JALR: begin
            imm  = {{20{w[31]}}, w[31:20]};
            base = read_model_reg(w[19:15]);
        end
        OP_BRANCH: imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        default:   ;
    endcase
    imm      = imm + base;
    b.target = imm[31:1];
    return b;
endfunction

// One rising edge of the barrier and the register file.
task automatic clock_model();
    insn_t w;
    logic  legal;
    w     = fetch.insn;
    legal = is_legal(w);
    if (!stall_id) begin
        exp_ex.valid          = fetch.valid && legal;
        exp_ex.pc             = fetch.pc;
        exp_ex.insn           = w;
        exp_ex.use_rd         = writes_rd(w);
        exp_ex.rs1_val        = read_model_reg(w[19:15]);
        exp_ex.rs2_val        = read_model_reg(w[24:20]);
        exp_ex.branch         = w[6:2] == OP_BRANCH;
        exp_ex.branch_predict = w[31];
        exp_ex.trap           = fetch.trap || (fetch.valid && !legal);
        exp_ex.cause          = fetch.trap ? fetch.cause : CAUSE_ILLEGAL;
    end else begin
        exp_ex.valid = exp_ex.valid && stall_ex;
    end
    if (wb.we && wb.rd != 5'd0) begin
        model_regs[wb.rd] = wb.wdata;
    end
endtask

`endif

//--- bench/tb_id_stage.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the decode stage. LFSR-driven instructions, write-backs
// and stalls, checked each cycle against the reference model.
// ~~~~~~~~~~~~~~~~~~~~

module tb_id_stage import id_decode_pkg::*; ();

    localparam bit has_m       = 1'b1;
    localparam bit has_zicsr   = 1'b1;
    localparam int num_cycles  = 2000;
    localparam int cycle_limit = 4 * num_cycles + 100;

    logic        clk;
    logic        rst;
    fetch_t      fetch;
    wb_t         wb;
    logic        stall_id;
    logic        stall_ex;
    branch_t     branch;
    id_ex_t      ex;
    logic [31:0] lfsr;
    int          cycles;
    int          ex_errors;
    int          branch_errors;
    int          word_errors;
    int          other_errors;

    `include "id_model.svh"

    id_stage #(
        .has_m     (has_m),
        .has_zicsr (has_zicsr)
    ) i_id_stage (
        .clk      (clk),
        .rst      (rst),
        .fetch    (fetch),
        .wb       (wb),
        .stall_id (stall_id),
        .stall_ex (stall_ex),
        .branch   (branch),
        .ex       (ex)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1.
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic insn_t make_insn();
        logic [4:0]  good_ops [11] = '{OP_LOAD, OP_MISC_MEM, OP_OP_IMM, OP_AUIPC, OP_STORE,
                                       OP_OP, OP_LUI, OP_BRANCH, OP_JALR, OP_JAL, OP_SYSTEM};
        // AMO, FP and reserved major opcodes.
        logic [4:0]  bad_ops [8]   = '{5'b01011, 5'b10100, 5'b00001, 5'b01001,
                                       5'b10000, 5'b11010, 5'b00010, 5'b11110};
        logic [6:0]  op_f7 [3]     = '{7'h00, 7'h20, 7'h01};
        logic [11:0] sys_f12 [4]   = '{12'h000, 12'h001, 12'h105, 12'h302};
        logic [3:0]  kind;
        insn_t       w;
        kind = 4'(take_bits(4));
        w    = take_bits(32);
        if (kind < 4'd10) begin
            w[6:0] = {good_ops[4'(take_bits(4) % 11)], 2'b11};
            if (w[6:2] == OP_OP) begin
                w[31:25] = op_f7[2'(take_bits(2) % 3)];
            end
            if (w[6:2] == OP_SYSTEM && w[14:12] == 3'd0) begin
                w[31:20] = sys_f12[2'(take_bits(2))];
            end
        end else if (kind < 4'd12) begin
            w[6:0] = {bad_ops[3'(take_bits(3))], 2'b11};
        end else if (kind < 4'd14) begin
            // Funct fields left fully random.
            w[6:0] = {good_ops[4'(take_bits(4) % 11)], 2'b11};
        end else if (w[1:0] == 2'b11) begin
            w[1:0] = 2'b10;
        end
        return w;
    endfunction

    task automatic drive_inputs(logic first);
        fetch.valid = take_bits(3) != 0;
        fetch.pc    = 31'(take_bits(31));
        fetch.insn  = make_insn();
        // IF reports a fault only without an instruction.
        fetch.trap  = (take_bits(1) == 1) ? !fetch.valid : 1'b0;
        fetch.cause = 4'(take_bits(4));
        wb.we       = take_bits(1) == 1;
        wb.rd       = (take_bits(2) == 0) ? fetch.insn[19:15] : 5'(take_bits(5));
        wb.wdata    = take_bits(32);
        stall_id    = first ? 1'b0 : take_bits(2) == 0;
        stall_ex    = take_bits(1) == 1;
    endtask

    task automatic check_ex(id_ex_t expected, id_ex_t actual);
        if (actual !== expected) begin
            $display("Error: ex expected %h, got %h", expected, actual);
            ex_errors++;
        end
    endtask

    task automatic check_branch(branch_t expected, branch_t actual);
        if (actual !== expected) begin
            $display("Error: branch expected %h, got %h", expected, actual);
            branch_errors++;
        end
    endtask

    task automatic check_word(string name, xlen_t expected, xlen_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h, got %h", name, expected, actual);
            word_errors++;
        end
    endtask

    initial begin
        lfsr          = 32'h24f4ca95;
        clk           = 1'b0;
        rst           = 1'b1;
        fetch         = '0;
        wb            = '0;
        stall_id      = 1'b0;
        stall_ex      = 1'b0;
        cycles        = 0;
        ex_errors     = 0;
        branch_errors = 0;
        word_errors   = 0;
        other_errors  = 0;
        exp_ex        = '0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        if (ex.valid !== 1'b0 || ex.trap !== 1'b0) begin
            $display("ex.valid or ex.trap is still set right after reset.");
            other_errors++;
        end
        drive_inputs(1'b1);
        #4;
        check_branch(expect_branch(), branch);
        for (int n = 0; n < num_cycles; n++) begin
            @(posedge clk);
            clock_model();
            #1;
            check_ex(exp_ex, ex);
            check_word("ex.rs1_val", exp_ex.rs1_val, ex.rs1_val);
            check_word("ex.rs2_val", exp_ex.rs2_val, ex.rs2_val);
            drive_inputs(1'b0);
            // Branch info settles combinationally from the new inputs.
            #4;
            check_branch(expect_branch(), branch);
        end
        $display("Errors: ex %0d, branch %0d, word %0d, other %0d",
                 ex_errors, branch_errors, word_errors, other_errors);
        if (ex_errors + branch_errors + word_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- src/branch_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// Early jump, branch and xret detection with target calculation.
// Feeds the fetch side in the same cycle.
// ~~~~~~~~~~~~~~~~~~~~

module branch_unit import id_decode_pkg::*; (
    input  insn_t   insn,
    input  pc_t     pc,
    input  xlen_t   rs1_val,
    output branch_t branch
);

    logic [4:0] opcode;
    xlen_t      pc_full;
    xlen_t      imm_j;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      base;
    xlen_t      offset;
    xlen_t      sum;

    assign opcode  = insn[6:2];
    assign pc_full = {pc, 1'b0};

    // Sign-extended immediates.
    assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};

    always_comb begin
        branch.is_xret   = 1'b0;
        branch.is_jump   = 1'b0;
        branch.is_branch = 1'b0;
        base             = pc_full;
        offset           = '0;
        case (opcode)
            OP_JAL: begin
                branch.is_jump = 1'b1;
                offset         = imm_j;
            end
            OP_JALR: begin
                branch.is_jump = 1'b1;
                base           = rs1_val;
                offset         = imm_i;
            end
            OP_BRANCH: begin
                branch.is_branch = 1'b1;
                offset           = imm_b;
            end
            OP_SYSTEM: begin
                branch.is_xret = insn[14:12] == 3'b000 && insn[31:20] == F12_MRET;
            end
            default: ;
        endcase
    end

    // Static prediction: backward branches have bit 31 set.
    assign branch.predict = insn[31];

    assign sum           = base + offset;
    assign branch.target = sum[31:1];

endmodule

//--- src/id_barrier.sv
// ~~~~~~~~~~~~~~~~~~~~
// ID/EX pipeline register with stall and drain handling.
// Makes the illegal instruction trap decision.
// ~~~~~~~~~~~~~~~~~~~~

module id_barrier import id_decode_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  fetch_t fetch,
    input  logic   insn_valid,
    input  logic   use_rd,
    input  xlen_t  rs1_val,
    input  xlen_t  rs2_val,
    input  logic   is_branch,
    input  logic   predict,
    input  logic   stall_id,
    input  logic   stall_ex,
    output id_ex_t ex
);

    id_ex_t next;

    always_comb begin
        next.valid          = fetch.valid && insn_valid;
        next.pc             = fetch.pc;
        next.insn           = fetch.insn;
        next.use_rd         = use_rd;
        next.rs1_val        = rs1_val;
        next.rs2_val        = rs2_val;
        next.branch         = is_branch;
        next.branch_predict = predict;
        // A trap from IF wins over a decode failure.
        next.trap           = fetch.trap || (fetch.valid && !insn_valid);
        next.cause          = fetch.trap ? fetch.cause : CAUSE_ILLEGAL;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.valid <= 1'b0;
            ex.trap  <= 1'b0;
        end else if (!stall_id) begin
            ex <= next;
        end else begin
            // EX took the item and ID has nothing new.
            ex.valid <= ex.valid && stall_ex;
        end
    end

endmodule

//--- src/id_decode_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared types and encodings for the instruction-decode stage.
// Imported by every decode module and by the testbench.
// ~~~~~~~~~~~~~~~~~~~~

package id_decode_pkg;

    // Widths with a meaning of their own.
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] insn_t;
    typedef logic [31:1] pc_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  cause_t;

    // Major opcodes, instruction bits 6 to 2.
    localparam logic [4:0] OP_LOAD     = 5'b00000;
    localparam logic [4:0] OP_MISC_MEM = 5'b00011;
    localparam logic [4:0] OP_OP_IMM   = 5'b00100;
    localparam logic [4:0] OP_AUIPC    = 5'b00101;
    localparam logic [4:0] OP_STORE    = 5'b01000;
    localparam logic [4:0] OP_OP       = 5'b01100;
    localparam logic [4:0] OP_LUI      = 5'b01101;
    localparam logic [4:0] OP_BRANCH   = 5'b11000;
    localparam logic [4:0] OP_JALR     = 5'b11001;
    localparam logic [4:0] OP_JAL      = 5'b11011;
    localparam logic [4:0] OP_SYSTEM   = 5'b11100;

    // SYSTEM instructions with funct3 of zero, by bits 31 to 20.
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_WFI    = 12'h105;
    localparam logic [11:0] F12_MRET   = 12'h302;

    // Illegal instruction trap cause.
    localparam cause_t CAUSE_ILLEGAL = 4'd2;

    // Instruction as handed over by IF.
    typedef struct packed {
        logic   valid;
        pc_t    pc;
        insn_t  insn;
        logic   trap;
        cause_t cause;
    } fetch_t;

    // Register write-back request.
    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        xlen_t    wdata;
    } wb_t;

    // Early control-flow info for the fetch side.
    typedef struct packed {
        logic is_xret;
        logic is_jump;
        logic is_branch;
        logic predict;
        pc_t  target;
    } branch_t;

    // Contents of the ID/EX barrier.
    typedef struct packed {
        logic   valid;
        pc_t    pc;
        insn_t  insn;
        logic   use_rd;
        xlen_t  rs1_val;
        xlen_t  rs2_val;
        logic   branch;
        logic   branch_predict;
        logic   trap;
        cause_t cause;
    } id_ex_t;

endpackage

//--- src/id_stage.sv
// ~~~~~~~~~~~~~~~~~~~~
// Instruction decode stage, top level.
// Takes the IF result and the write-back port, feeds EX and fetch.
// ~~~~~~~~~~~~~~~~~~~~

module id_stage import id_decode_pkg::*; #(
    parameter bit has_m     = 1'b1,
    parameter bit has_zicsr = 1'b1
) (
    input  logic    clk,
    input  logic    rst,
    // From IF.
    input  fetch_t  fetch,
    // Register write-back.
    input  wb_t     wb,
    input  logic    stall_id,
    input  logic    stall_ex,
    // Early control flow, combinational.
    output branch_t branch,
    // To EX.
    output id_ex_t  ex
);

    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    logic     insn_valid;
    logic     use_rd;

    assign rs1 = fetch.insn[19:15];
    assign rs2 = fetch.insn[24:20];

    reg_file i_reg_file (
        .clk     (clk),
        .rst     (rst),
        .wb      (wb),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    opcode_decoder #(
        .has_m     (has_m),
        .has_zicsr (has_zicsr)
    ) i_opcode_decoder (
        .insn       (fetch.insn),
        .insn_valid (insn_valid),
        .use_rd     (use_rd)
    );

    branch_unit i_branch_unit (
        .insn    (fetch.insn),
        .pc      (fetch.pc),
        .rs1_val (rs1_val),
        .branch  (branch)
    );

    id_barrier i_id_barrier (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .insn_valid (insn_valid),
        .use_rd     (use_rd),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .is_branch  (branch.is_branch),
        .predict    (branch.predict),
        .stall_id   (stall_id),
        .stall_ex   (stall_ex),
        .ex         (ex)
    );

endmodule

//--- src/opcode_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// Checks a 32-bit word against RV32I, optionally M and Zicsr.
// Also tells whether the instruction writes rd.
// ~~~~~~~~~~~~~~~~~~~~

module opcode_decoder import id_decode_pkg::*; #(
    parameter bit has_m     = 1'b1,
    parameter bit has_zicsr = 1'b1
) (
    input  insn_t insn,
    output logic  insn_valid,
    output logic  use_rd
);

    logic [4:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;

    assign opcode  = insn[6:2];
    assign funct3  = insn[14:12];
    assign funct7  = insn[31:25];
    assign funct12 = insn[31:20];

    // Immediate shifts carry funct7 in the upper immediate bits.
    logic valid_op_imm;
    always_comb begin
        case (funct3)
            3'b001:  valid_op_imm = funct7 == 7'h00;
            3'b101:  valid_op_imm = funct7 == 7'h00 || funct7 == 7'h20;
            default: valid_op_imm = 1'b1;
        endcase
    end

    // Register-register ALU and M extension.
    logic valid_op;
    always_comb begin
        case (funct7)
            7'h00:   valid_op = 1'b1;
            // Only SUB and SRA.
            7'h20:   valid_op = funct3 == 3'b000 || funct3 == 3'b101;
            7'h01:   valid_op = has_m;
            default: valid_op = 1'b0;
        endcase
    end

    logic valid_system;
    always_comb begin
        if (funct3 == 3'b000) begin
            valid_system = funct12 == F12_ECALL || funct12 == F12_EBREAK
                        || funct12 == F12_MRET  || funct12 == F12_WFI;
        end else if (funct3 == 3'b100) begin
            valid_system = 1'b0;
        end else begin
            // CSR accesses.
            valid_system = has_zicsr;
        end
    end

    always_comb begin
        insn_valid = 1'b0;
        use_rd     = 1'b0;
        case (opcode)
            OP_LOAD: begin
                insn_valid = funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111;
                use_rd     = 1'b1;
            end
            OP_MISC_MEM: insn_valid = funct3[2:1] == 2'b00;
            OP_OP_IMM: begin
                insn_valid = valid_op_imm;
                use_rd     = 1'b1;
            end
            OP_AUIPC, OP_LUI, OP_JAL: begin
                insn_valid = 1'b1;
                use_rd     = 1'b1;
            end
            OP_STORE: insn_valid = funct3 < 3'd3;
            OP_OP: begin
                insn_valid = valid_op;
                use_rd     = 1'b1;
            end
            OP_BRANCH: insn_valid = funct3[2] || !funct3[1];
            OP_JALR: begin
                insn_valid = funct3 == 3'b000;
                use_rd     = 1'b1;
            end
            OP_SYSTEM: begin
                insn_valid = valid_system;
                use_rd     = funct3 != 3'b000;
            end
            default: ;
        endcase
        // Compressed or longer encodings are not supported.
        if (insn[1:0] != 2'b11) begin
            insn_valid = 1'b0;
        end
    end

endmodule

//--- src/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~
// Write-first register file, two read ports and one write port.
// Register 0 is hardwired to zero.
// ~~~~~~~~~~~~~~~~~~~~

module reg_file import id_decode_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // Write port.
    input  wb_t      wb,
    // Read indices.
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    // Read data.
    output xlen_t    rs1_val,
    output xlen_t    rs2_val
);

    // x1 to x31 only.
    xlen_t regs [31:1];

    // Zero for x0, pending write data on a hit, storage otherwise.
    function automatic xlen_t read_reg(reg_idx_t idx);
        xlen_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb.we && wb.rd == idx) begin
            val = wb.wdata;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_val = read_reg(rs1);
        rs2_val = read_reg(rs2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.rd != '0) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

endmodule

//--- vlog.f
+incdir+bench
src/id_decode_pkg.sv
src/reg_file.sv
src/opcode_decoder.sv
src/branch_unit.sv
src/id_barrier.sv
src/id_stage.sv
bench/id_stage_props.sv
bench/tb_id_stage.sv
